/* hdl/cache_ctrl.sv */
`timescale 1ns/10ps

module cache_ctrl #(
    parameter int INDEX_BITS = 8
) (
    input  logic                                   clk,
    input  logic                                   resetn,
    input  logic                                   valid,
    input  logic                                   op,
    input  logic [INDEX_BITS-1:0]                  index,
    input  cache_pkg::tag_t                        tag,
    input  logic [cache_pkg::OFFSET_BITS-1:0]      offset,
    input  logic [3:0]                             wstrb,
    input  cache_pkg::word_t                       wdata,
    output logic                                   addr_ok,
    output logic                                   data_ok,
    output cache_pkg::word_t                       rdata,
    output logic                                   rd_req,
    output logic [31:0]                            rd_addr,
    input  logic                                   rd_rdy,
    input  logic                                   ret_valid,
    input  logic                                   ret_last,
    input  cache_pkg::word_t                       ret_data,
    output logic                                   wr_req,
    output logic [31:0]                            wr_addr,
    output logic [cache_pkg::WORDS_PER_LINE*32-1:0] wr_data,
    input  logic                                   wr_rdy,
    output logic [INDEX_BITS-1:0]                  way_index,
    output logic [cache_pkg::OFFSET_BITS-1:0]      lookup_offset,
    output cache_pkg::way_vec_t                    tag_wen,
    output logic [cache_pkg::NUM_WAYS-1:0][cache_pkg::WORDS_PER_LINE-1:0] data_wen,
    output cache_pkg::way_vec_t                    valid_wen,
    output cache_pkg::way_vec_t                    dirty_wen,
    output cache_pkg::tag_t                        wtag,
    output cache_pkg::word_t                       wword,
    output logic                                   valid_in,
    output logic                                   dirty_in,
    input  logic                                   hit,
    input  cache_pkg::way_vec_t                    hit_way,
    input  cache_pkg::word_t                       sel_word,
    input  cache_pkg::way_vec_t                    victim_way,
    input  logic                                   victim_dirty,
    input  cache_pkg::tag_t                        victim_tag,
    input  logic [cache_pkg::WORDS_PER_LINE*32-1:0] victim_line,
    output logic                                   lru_touch,
    output cache_pkg::way_vec_t                    lru_way
);

    cache_pkg::ctrl_state_t state, next_state;

    logic                  req_op;
    logic [INDEX_BITS-1:0] req_index;
    cache_pkg::tag_t       req_tag;
    logic [3:0]            req_wstrb;
    cache_pkg::word_t      req_wdata;
    logic [1:0]            req_word;
    cache_pkg::way_vec_t   repl_way;      // hit way, or victim on a miss
    logic                  vict_dirty_q;
    cache_pkg::tag_t       vict_tag_q;
    logic [cache_pkg::WORDS_PER_LINE*32-1:0] vict_line_q;
    logic [1:0]            beat_cnt;
    cache_pkg::word_t      miss_word;
    cache_pkg::word_t      refill_word;
    logic                  last_beat;
    logic [1:0]            wr_bank;
    logic                  bank_we;

    function automatic cache_pkg::word_t merge_word(input cache_pkg::word_t old_word,
                                                    input cache_pkg::word_t new_word,
                                                    input logic [3:0] strb);
        cache_pkg::word_t res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= cache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            cache_pkg::IDLE:    if (valid) next_state = cache_pkg::LOOKUP;
            cache_pkg::LOOKUP: begin
                if (!hit) begin
                    next_state = cache_pkg::MISS;
                end else if (req_op == cache_pkg::OP_WRITE) begin
                    next_state = cache_pkg::WRITE;
                end else begin
                    next_state = cache_pkg::IDLE;
                end
            end
            cache_pkg::WRITE:   next_state = cache_pkg::IDLE;
            cache_pkg::MISS:    if (!vict_dirty_q || wr_rdy) next_state = cache_pkg::REPLACE;
            cache_pkg::REPLACE: if (rd_rdy) next_state = cache_pkg::REFILL;
            cache_pkg::REFILL:  if (last_beat) next_state = cache_pkg::IDLE;
            default:            next_state = cache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == cache_pkg::IDLE && valid) begin   // accept the request
            req_op    <= op;
            req_index <= index;
            req_tag   <= tag;
            req_wstrb <= wstrb;
            req_wdata <= wdata;
            req_word  <= offset[cache_pkg::OFFSET_BITS-1:2];
        end
        if (state == cache_pkg::LOOKUP) begin
            repl_way     <= hit ? hit_way : victim_way;
            vict_dirty_q <= victim_dirty;
            vict_tag_q   <= victim_tag;
            vict_line_q  <= victim_line;   // held for the writeback
        end
        if (state == cache_pkg::REFILL && ret_valid && beat_cnt == req_word) begin
            miss_word <= refill_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn || state == cache_pkg::REPLACE) begin
            beat_cnt <= '0;
        end else if (state == cache_pkg::REFILL && ret_valid) begin
            beat_cnt <= beat_cnt + 2'd1;
        end
    end

    assign last_beat   = (state == cache_pkg::REFILL) && ret_valid && ret_last;
    assign refill_word = (beat_cnt == req_word && req_op == cache_pkg::OP_WRITE)
                         ? merge_word(ret_data, req_wdata, req_wstrb) : ret_data;

    assign addr_ok = (state == cache_pkg::IDLE);
    assign data_ok = (state == cache_pkg::LOOKUP && hit) || last_beat;
    assign rdata   = (state == cache_pkg::LOOKUP) ? sel_word
                   : (beat_cnt == req_word) ? ret_data : miss_word;

    assign rd_req  = (state == cache_pkg::REPLACE);
    assign rd_addr = 32'({req_tag, req_index, cache_pkg::OFFSET_BITS'(0)});
    assign wr_req  = (state == cache_pkg::MISS) && vict_dirty_q;
    assign wr_addr = 32'({vict_tag_q, req_index, cache_pkg::OFFSET_BITS'(0)});
    assign wr_data = vict_line_q;

    assign way_index     = (state == cache_pkg::IDLE) ? index : req_index;
    assign lookup_offset = {req_word, 2'b00};
    assign wtag          = req_tag;
    assign wword         = (state == cache_pkg::WRITE)
                           ? merge_word(sel_word, req_wdata, req_wstrb) : refill_word;
    assign valid_in      = 1'b1;
    assign dirty_in      = (req_op == cache_pkg::OP_WRITE);   // a read refill leaves it clean

    assign wr_bank = (state == cache_pkg::WRITE) ? req_word : beat_cnt;
    assign bank_we = (state == cache_pkg::WRITE) || (state == cache_pkg::REFILL && ret_valid);

    always_comb begin
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            for (int b = 0; b < cache_pkg::WORDS_PER_LINE; b++) begin
                data_wen[w][b] = bank_we && repl_way[w] && (wr_bank == b);
            end
        end
    end

    assign tag_wen   = last_beat ? repl_way : '0;
    assign valid_wen = last_beat ? repl_way : '0;
    assign dirty_wen = (last_beat || state == cache_pkg::WRITE) ? repl_way : '0;

    assign lru_touch = (state == cache_pkg::LOOKUP && hit) || last_beat;
    assign lru_way   = (state == cache_pkg::LOOKUP) ? hit_way : repl_way;

    a_rd_req_held: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req) else $error("rd_req dropped before rd_rdy");

    a_ok_exclusive: assert property (@(posedge clk) disable iff (!resetn)
        !(data_ok && addr_ok)) else $error("data_ok together with addr_ok");

endmodule

/* hdl/cache_pkg.sv */
package cache_pkg;

    localparam int NUM_WAYS       = 2;   // one lru bit per set covers two ways
    localparam int TAG_BITS       = 20;
    localparam int OFFSET_BITS    = 4;   // byte offset inside a 16-byte line
    localparam int WORDS_PER_LINE = 4;

    typedef logic [31:0]          word_t;
    typedef logic [TAG_BITS-1:0]  tag_t;
    typedef logic [NUM_WAYS-1:0]  way_vec_t;   // one bit per way

    localparam logic OP_READ  = 1'b0;
    localparam logic OP_WRITE = 1'b1;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,      // writeback of a dirty victim
        REPLACE,   // refill request to memory
        REFILL,
        WRITE      // write hit updates the bank
    } ctrl_state_t;

endpackage

/* hdl/cache_top.sv */
`timescale 1ns/10ps

module cache_top #(
    parameter int INDEX_BITS = 8
) (
    input  logic                                   clk,
    input  logic                                   resetn,
    input  logic                                   valid,
    input  logic                                   op,
    input  logic [INDEX_BITS-1:0]                  index,
    input  cache_pkg::tag_t                        tag,
    input  logic [cache_pkg::OFFSET_BITS-1:0]      offset,
    input  logic [3:0]                             wstrb,
    input  cache_pkg::word_t                       wdata,
    output logic                                   addr_ok,
    output logic                                   data_ok,
    output cache_pkg::word_t                       rdata,
    output logic                                   rd_req,
    output logic [31:0]                            rd_addr,
    input  logic                                   rd_rdy,
    input  logic                                   ret_valid,
    input  logic                                   ret_last,
    input  cache_pkg::word_t                       ret_data,
    output logic                                   wr_req,
    output logic [31:0]                            wr_addr,
    output logic [cache_pkg::WORDS_PER_LINE*32-1:0] wr_data,
    input  logic                                   wr_rdy
);

    wire [INDEX_BITS-1:0]                  way_index;
    wire [cache_pkg::OFFSET_BITS-1:0]      lookup_offset;
    wire cache_pkg::way_vec_t              tag_wen, valid_wen, dirty_wen;
    wire [cache_pkg::NUM_WAYS-1:0][cache_pkg::WORDS_PER_LINE-1:0] data_wen;
    wire cache_pkg::tag_t                  wtag;
    wire cache_pkg::word_t                 wword;
    wire                                   valid_in, dirty_in;
    wire cache_pkg::tag_t [cache_pkg::NUM_WAYS-1:0] way_tags;
    wire cache_pkg::way_vec_t              way_valids, way_dirtys;
    wire cache_pkg::word_t [cache_pkg::NUM_WAYS-1:0][cache_pkg::WORDS_PER_LINE-1:0] way_words;
    wire                                   hit, victim_dirty, lru_touch;
    wire cache_pkg::way_vec_t              hit_way, victim_way, lru_way;
    wire cache_pkg::word_t                 sel_word;
    wire cache_pkg::tag_t                  victim_tag;
    wire [cache_pkg::WORDS_PER_LINE*32-1:0] victim_line;

    cache_ctrl #(.INDEX_BITS(INDEX_BITS)) ctrl_i (
        .clk, .resetn, .valid, .op, .index, .tag, .offset, .wstrb, .wdata,
        .addr_ok, .data_ok, .rdata,
        .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy,
        .way_index, .lookup_offset, .tag_wen, .data_wen, .valid_wen, .dirty_wen,
        .wtag, .wword, .valid_in, .dirty_in,
        .hit, .hit_way, .sel_word, .victim_way, .victim_dirty, .victim_tag, .victim_line,
        .lru_touch, .lru_way
    );

    for (genvar w = 0; w < cache_pkg::NUM_WAYS; w++) begin : g_way
        cache_way #(.INDEX_BITS(INDEX_BITS)) way_i (
            .clk       (clk),
            .resetn    (resetn),
            .index     (way_index),
            .tag_wen   (tag_wen[w]),
            .data_wen  (data_wen[w]),
            .valid_wen (valid_wen[w]),
            .dirty_wen (dirty_wen[w]),
            .wtag      (wtag),
            .wword     (wword),
            .valid_in  (valid_in),
            .dirty_in  (dirty_in),
            .rtag      (way_tags[w]),
            .rvalid    (way_valids[w]),
            .rdirty    (way_dirtys[w]),
            .rwords    (way_words[w])
        );
    end

    way_select #(.INDEX_BITS(INDEX_BITS)) select_i (
        .clk, .resetn,
        .lookup_index  (way_index),
        .lookup_tag    (wtag),          // registered request tag
        .lookup_offset (lookup_offset),
        .way_tags, .way_valids, .way_dirtys, .way_words,
        .lru_touch, .lru_way,
        .hit, .hit_way, .sel_word, .victim_way, .victim_dirty, .victim_tag, .victim_line
    );

endmodule

/* hdl/cache_way.sv */
`timescale 1ns/10ps

module cache_way #(
    parameter int INDEX_BITS = 8
) (
    input  logic                                        clk,
    input  logic                                        resetn,
    input  logic [INDEX_BITS-1:0]                       index,
    input  logic                                        tag_wen,
    input  logic [cache_pkg::WORDS_PER_LINE-1:0]        data_wen,
    input  logic                                        valid_wen,
    input  logic                                        dirty_wen,
    input  cache_pkg::tag_t                             wtag,
    input  cache_pkg::word_t                            wword,
    input  logic                                        valid_in,
    input  logic                                        dirty_in,
    output cache_pkg::tag_t                             rtag,
    output logic                                        rvalid,
    output logic                                        rdirty,
    output cache_pkg::word_t [cache_pkg::WORDS_PER_LINE-1:0] rwords
);

    logic [INDEX_BITS-1:0] index_q;   // matches the ram read latency

    always_ff @(posedge clk) begin
        index_q <= index;
    end

    storage_ram #(.INDEX_BITS(INDEX_BITS), .entry_t(cache_pkg::tag_t)) tag_ram_i (
        .clk   (clk),
        .addr  (index),
        .wen   (tag_wen),
        .wdata (wtag),
        .rdata (rtag)
    );

    for (genvar b = 0; b < cache_pkg::WORDS_PER_LINE; b++) begin : g_bank
        storage_ram #(.INDEX_BITS(INDEX_BITS), .entry_t(cache_pkg::word_t)) bank_i (
            .clk   (clk),
            .addr  (index),
            .wen   (data_wen[b]),
            .wdata (wword),
            .rdata (rwords[b])
        );
    end

    flag_table #(.INDEX_BITS(INDEX_BITS)) valid_tbl_i (
        .clk    (clk),
        .resetn (resetn),
        .waddr  (index),
        .raddr  (index_q),
        .wen    (valid_wen),
        .wdata  (valid_in),
        .rdata  (rvalid)
    );

    flag_table #(.INDEX_BITS(INDEX_BITS)) dirty_tbl_i (
        .clk    (clk),
        .resetn (resetn),
        .waddr  (index),
        .raddr  (index_q),
        .wen    (dirty_wen),
        .wdata  (dirty_in),
        .rdata  (rdirty)
    );

endmodule

/* hdl/flag_table.sv */
`timescale 1ns/10ps

module flag_table #(
    parameter int INDEX_BITS = 8
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [INDEX_BITS-1:0] waddr,
    input  logic [INDEX_BITS-1:0] raddr,
    input  logic                  wen,
    input  logic                  wdata,
    output logic                  rdata
);

    logic [2**INDEX_BITS-1:0] bits;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            bits <= '0;
        end else if (wen) begin
            bits[waddr] <= wdata;
        end
    end

    assign rdata = bits[raddr];   // no read latency

    // writers upstream must stay quiet for the whole reset
    a_no_write_in_reset: assert property (@(posedge clk) !resetn && $past(!resetn) |-> !wen)
        else $error("flag_table written during reset");

endmodule

/* hdl/storage_ram.sv */
`timescale 1ns/10ps

module storage_ram #(
    parameter int  INDEX_BITS = 8,
    parameter type entry_t    = logic [31:0]
) (
    input  logic                  clk,
    input  logic [INDEX_BITS-1:0] addr,
    input  logic                  wen,
    input  entry_t                wdata,
    output entry_t                rdata
);

    entry_t mem [2**INDEX_BITS];

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];   // old value on a same-cycle write
    end

endmodule

/* hdl/way_select.sv */
`timescale 1ns/10ps

module way_select #(
    parameter int INDEX_BITS = 8
) (
    input  logic                                   clk,
    input  logic                                   resetn,
    input  logic [INDEX_BITS-1:0]                  lookup_index,
    input  cache_pkg::tag_t                        lookup_tag,
    input  logic [cache_pkg::OFFSET_BITS-1:0]      lookup_offset,
    input  cache_pkg::tag_t [cache_pkg::NUM_WAYS-1:0] way_tags,
    input  cache_pkg::way_vec_t                    way_valids,
    input  cache_pkg::way_vec_t                    way_dirtys,
    input  cache_pkg::word_t [cache_pkg::NUM_WAYS-1:0][cache_pkg::WORDS_PER_LINE-1:0] way_words,
    input  logic                                   lru_touch,
    input  cache_pkg::way_vec_t                    lru_way,
    output logic                                   hit,
    output cache_pkg::way_vec_t                    hit_way,
    output cache_pkg::word_t                       sel_word,
    output cache_pkg::way_vec_t                    victim_way,
    output logic                                   victim_dirty,
    output cache_pkg::tag_t                        victim_tag,
    output logic [cache_pkg::WORDS_PER_LINE*32-1:0] victim_line
);

    logic mru;    // most recently used way of the set
    logic vidx;

    always_comb begin
        hit_way  = '0;
        sel_word = '0;
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            hit_way[w] = way_valids[w] && (way_tags[w] == lookup_tag);
            if (hit_way[w]) begin
                sel_word = way_words[w][lookup_offset[cache_pkg::OFFSET_BITS-1:2]];
            end
        end
    end

    assign hit = |hit_way;

    // empty way first, else the one not used last
    always_comb begin
        if (!way_valids[0]) begin
            victim_way = 2'b01;
        end else if (!way_valids[1]) begin
            victim_way = 2'b10;
        end else begin
            victim_way = mru ? 2'b01 : 2'b10;
        end
    end

    assign vidx         = victim_way[1];
    assign victim_tag   = way_tags[vidx];
    assign victim_dirty = way_valids[vidx] && way_dirtys[vidx];
    assign victim_line  = way_words[vidx];

    flag_table #(.INDEX_BITS(INDEX_BITS)) lru_tbl_i (
        .clk    (clk),
        .resetn (resetn),
        .waddr  (lookup_index),
        .raddr  (lookup_index),
        .wen    (lru_touch),
        .wdata  (lru_way[1]),
        .rdata  (mru)
    );

    a_one_hit: assert property (@(posedge clk) disable iff (!resetn) $onehot0(hit_way))
        else $error("tag present in more than one way");

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_cache -f tb.f -o tb_cache_sim
./obj_dir/tb_cache_sim > sim.log 2>&1
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* tb.f */
hdl/cache_pkg.sv
hdl/storage_ram.sv
hdl/flag_table.sv
hdl/cache_way.sv
hdl/way_select.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
tests/axi_mem_model.sv
tests/tb_cache.sv

/* tests/axi_mem_model.sv */
`timescale 1ns/10ps

module axi_mem_model #(
    parameter logic [31:0] PATTERN = 32'hc0de_0000
) (
    input  logic         clk,
    input  logic         resetn,
    input  logic         rd_req,
    input  logic [31:0]  rd_addr,
    output logic         rd_rdy,
    output logic         ret_valid,
    output logic         ret_last,
    output logic [31:0]  ret_data,
    input  logic         wr_req,
    input  logic [31:0]  wr_addr,
    input  logic [127:0] wr_data,
    output logic         wr_rdy,
    output int           wb_count
);

    logic [31:0] mem [logic [31:0]];   // only written-back words live here
    logic [31:0] rd_base;
    int          rd_stall;
    int          wr_stall;
    int          gap;                  // idle cycles before the next beat
    int          beat;
    bit          refilling;

    // untouched words follow the address pattern
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return addr ^ PATTERN;
    endfunction

    always @(posedge clk) begin
        if (!resetn) begin
            rd_rdy    <= 1'b0;
            wr_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            ret_data  <= '0;
            rd_base   <= '0;
            wb_count  <= 0;
            beat      <= 0;
            gap       <= 0;
            refilling <= 1'b0;
            rd_stall  <= $urandom_range(3, 0);
            wr_stall  <= $urandom_range(3, 0);
        end else begin
            rd_rdy    <= 1'b0;
            wr_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            if (wr_req && !wr_rdy) begin
                if (wr_stall == 0) begin
                    wr_rdy <= 1'b1;
                    for (int b = 0; b < 4; b++) begin
                        mem[wr_addr + 32'(4 * b)] = wr_data[32*b +: 32];
                    end
                    wb_count <= wb_count + 1;
                    wr_stall <= $urandom_range(4, 0);
                end else begin
                    wr_stall <= wr_stall - 1;
                end
            end
            if (refilling) begin
                if (gap == 0) begin
                    ret_valid <= 1'b1;
                    ret_last  <= (beat == 3);
                    ret_data  <= read_word(rd_base + 32'(4 * beat));
                    beat      <= beat + 1;
                    refilling <= (beat != 3);
                    gap       <= $urandom_range(2, 0);
                end else begin
                    gap <= gap - 1;
                end
            end else if (rd_req && !rd_rdy) begin
                if (rd_stall == 0) begin
                    rd_rdy    <= 1'b1;
                    rd_base   <= rd_addr;
                    beat      <= 0;
                    refilling <= 1'b1;
                    gap       <= $urandom_range(2, 0);
                    rd_stall  <= $urandom_range(4, 0);
                end else begin
                    rd_stall <= rd_stall - 1;
                end
            end
        end
    end

endmodule

/* tests/cache_input.txt */
# op index tag offset wstrb wdata expected miss wb, all hex; op 0 reads, op 1 writes
# expected is the read data (unused on writes); miss and wb say if rd_req and wr_req fire
0 05 00001 4 0 00000000 c0de1054 1 0
0 05 00001 c 0 00000000 c0de105c 0 0
1 05 00001 8 3 11223344 00000000 0 0
0 05 00001 8 0 00000000 c0de3344 0 0
1 05 00002 0 c aabbccdd 00000000 1 0
0 05 00002 0 0 00000000 aabb2050 0 0
0 05 00003 4 0 00000000 c0de3054 1 1
0 05 00001 8 0 00000000 c0de3344 1 1
0 05 00004 0 0 00000000 c0de4050 1 0
0 05 00002 0 0 00000000 aabb2050 1 0
1 1f 00005 8 1 000000ee 00000000 1 0
0 1f 00005 8 0 00000000 c0de51ee 0 0
1 1f 00005 8 4 00770000 00000000 0 0
0 1f 00005 8 0 00000000 c07751ee 0 0
1 1f 00006 4 f 12345678 00000000 1 0
1 1f 00007 0 2 0000ab00 00000000 1 1
0 1f 00006 4 0 00000000 12345678 0 0
0 1f 00005 8 0 00000000 c07751ee 1 1
0 1f 00007 0 0 00000000 c0deabf0 1 1
0 00 00000 0 0 00000000 c0de0000 1 0
0 ff abcde c 0 00000000 6b13effc 1 0
0 ff abcde 0 0 00000000 6b13eff0 0 0
1 00 00000 4 f deadbeef 00000000 0 0
0 00 00000 4 0 00000000 deadbeef 0 0

/* tests/tb_cache.sv */
`timescale 1ns/10ps

module tb_cache;

    localparam int          INDEX_BITS = 8;
    localparam logic [31:0] PATTERN    = 32'hc0de_0000;   // memory word is address ^ PATTERN
    localparam int          SEED       = 94062;
    localparam int          WAIT_LIMIT = 200;             // cycles allowed per wait loop

    logic                              clk;
    logic                              resetn;
    logic                              valid;
    logic                              op;
    logic [INDEX_BITS-1:0]             index;
    cache_pkg::tag_t                   tag;
    logic [cache_pkg::OFFSET_BITS-1:0] offset;
    logic [3:0]                        wstrb;
    cache_pkg::word_t                  wdata;
    logic                              addr_ok;
    logic                              data_ok;
    cache_pkg::word_t                  rdata;
    logic                              rd_req;
    logic [31:0]                       rd_addr;
    logic                              rd_rdy;
    logic                              ret_valid;
    logic                              ret_last;
    cache_pkg::word_t                  ret_data;
    logic                              wr_req;
    logic [31:0]                       wr_addr;
    logic [127:0]                      wr_data;
    logic                              wr_rdy;
    int                                wb_count;

    int               errors;
    int               test_errors;
    int               rd_seen;
    int               wr_seen;
    bit               timed_out;
    logic [31:0]      line_addr;                 // line base of the current request
    cache_pkg::word_t shadow [logic [31:0]];   // cpu view of memory

    cache_top #(.INDEX_BITS(INDEX_BITS)) dut_i (
        .clk, .resetn, .valid, .op, .index, .tag, .offset, .wstrb, .wdata,
        .addr_ok, .data_ok, .rdata,
        .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy
    );

    axi_mem_model #(.PATTERN(PATTERN)) mem_i (
        .clk, .resetn, .rd_req, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy, .wb_count
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            $display("mismatch at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    function automatic cache_pkg::word_t stored_word(input logic [31:0] addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return addr ^ PATTERN;
    endfunction

    function automatic logic [127:0] expected_line(input logic [31:0] base);
        logic [127:0] line;
        for (int b = 0; b < 4; b++) begin
            line[32*b +: 32] = stored_word(base + 32'(4 * b));
        end
        return line;
    endfunction

    // byte merge of a cpu write into the shadow
    task automatic record_write(input logic [31:0] addr, input logic [3:0] strb,
                                input cache_pkg::word_t data);
        cache_pkg::word_t word;
        word = stored_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                word[8*b +: 8] = data[8*b +: 8];
            end
        end
        shadow[addr] = word;
    endtask

    task automatic run_request(input logic req_op, input logic [INDEX_BITS-1:0] req_index,
                               input cache_pkg::tag_t req_tag, input logic [3:0] req_offset,
                               input logic [3:0] req_wstrb, input cache_pkg::word_t req_wdata,
                               output cache_pkg::word_t got);
        int waited;
        got = '0;
        @(posedge clk);
        valid  <= 1'b1;
        op     <= req_op;
        index  <= req_index;
        tag    <= req_tag;
        offset <= req_offset;
        wstrb  <= req_wstrb;
        wdata  <= req_wdata;
        waited = 0;
        @(negedge clk);
        while (!addr_ok && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!addr_ok) begin
            $display("timeout at %0t ns: the cache never accepted the request", $time);
            timed_out = 1'b1;
        end else begin
            @(posedge clk);
            valid <= 1'b0;   // accepted on this edge
            waited = 0;
            @(negedge clk);
            while (!data_ok && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (!data_ok) begin
                $display("timeout at %0t ns: data_ok never came for the request", $time);
                timed_out = 1'b1;
            end else begin
                got = rdata;
            end
        end
    endtask

    // memory handshakes complete on the edge after these samples
    always @(negedge clk) begin
        if (resetn && rd_req && rd_rdy) begin
            check_value("rd_addr", line_addr, rd_addr);
            rd_seen++;
        end
        if (resetn && wr_req && wr_rdy) begin
            check_value("wr_data", expected_line(wr_addr), wr_data);
            wr_seen++;
        end
    end

    initial begin
        int               fd;
        int               n;
        int               tests;
        int               failed;
        int               wb_expected;
        int               rd_before;
        int               wr_before;
        string            line;
        logic [31:0]      f_op, f_index, f_tag, f_offset, f_wstrb, f_wdata, f_exp, f_miss, f_wb;
        cache_pkg::word_t got;
        errors      = 0;
        test_errors = 0;
        rd_seen     = 0;
        wr_seen     = 0;
        timed_out   = 1'b0;
        line_addr   = '0;
        tests       = 0;
        failed      = 0;
        wb_expected = 0;
        resetn      = 1'b0;
        valid       = 1'b0;
        op          = cache_pkg::OP_READ;
        index       = '0;
        tag         = '0;
        offset      = '0;
        wstrb       = '0;
        wdata       = '0;
        void'($urandom(SEED));
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        check_value("addr_ok", 1, addr_ok);
        check_value("data_ok", 0, data_ok);
        check_value("rd_req", 0, rd_req);
        check_value("wr_req", 0, wr_req);
        $display("test 0 reset state %s", (test_errors == 0) ? "ok" : "failed");
        fd = $fopen("tests/cache_input.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/cache_input.txt");
            errors++;
        end else begin
            while (!timed_out && $fgets(line, fd) > 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f_op, f_index, f_tag,
                            f_offset, f_wstrb, f_wdata, f_exp, f_miss, f_wb);
                if (n != 9) begin
                    $display("unreadable line in the input file: %s", line);
                    errors++;
                    continue;
                end
                tests++;
                test_errors = 0;
                wb_expected += int'(f_wb);
                rd_before = rd_seen;
                wr_before = wr_seen;
                line_addr = 32'({f_tag[cache_pkg::TAG_BITS-1:0], f_index[INDEX_BITS-1:0],
                                 4'b0000});
                run_request(f_op[0], f_index[INDEX_BITS-1:0], f_tag[cache_pkg::TAG_BITS-1:0],
                            f_offset[3:0], f_wstrb[3:0], f_wdata, got);
                if (!timed_out) begin
                    if (f_op[0] == cache_pkg::OP_WRITE) begin
                        record_write({f_tag[cache_pkg::TAG_BITS-1:0], f_index[INDEX_BITS-1:0],
                                      f_offset[3:2], 2'b00}, f_wstrb[3:0], f_wdata);
                    end else begin
                        check_value("rdata", f_exp, got);
                    end
                    check_value("rd_req", f_miss, rd_seen - rd_before);
                    check_value("wr_req", f_wb, wr_seen - wr_before);
                end
                if (test_errors != 0 || timed_out) begin
                    failed++;
                end
                $display("test %0d %s index %h tag %h offset %h %s", tests,
                         f_op[0] ? "write" : "read", f_index[INDEX_BITS-1:0],
                         f_tag[cache_pkg::TAG_BITS-1:0], f_offset[3:0],
                         (test_errors == 0 && !timed_out) ? "ok" : "failed");
            end
            $fclose(fd);
        end
        check_value("wb_count", wb_expected, wb_count);
        $display("%0d tests, %0d failed, %0d writebacks, %0d errors", tests, failed,
                 wb_count, errors);
        if (errors == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
